// File: dcache_pkg.sv
// **********************************************************************
// shared geometry, address view, frame and port types for the data cache
// every cache file refers to these through dcache_pkg:: scoped names
// **********************************************************************
`default_nettype none

package dcache_pkg;

	localparam int word_width      = 32;
	localparam int num_ways        = 2;
	localparam int num_sets        = 8;
	localparam int index_width     = 3;
	localparam int tag_width       = 26;
	localparam int words_per_block = 2;
	localparam int num_frames      = 16; // ways times sets, flush walk length

	typedef logic [word_width-1:0]  word_t;
	typedef logic [tag_width-1:0]   tag_t;
	typedef logic [index_width-1:0] index_t;

	// lookup split of a byte address
	typedef struct packed {
		tag_t       tag;
		index_t     index;
		logic       word_sel; // word within the block
		logic [1:0] byte_off;
	} addr_fields_t;

	// whole word toward memory, fields for lookup
	typedef union packed {
		word_t        word;
		addr_fields_t fields;
	} dcache_addr_t;

	typedef struct packed {
		logic                              valid;
		logic                              dirty;
		tag_t                              tag;
		word_t [words_per_block-1:0]       data;
	} frame_t;

	typedef struct packed {
		logic [num_ways-1:0] valid;
		logic [num_ways-1:0] dirty;
		logic                hit;
		logic                hit_way;
	} set_status_t;

	// one frame update per cycle, valid, dirty and tag are always rewritten
	typedef struct packed {
		logic   en;
		logic   way;
		index_t index;
		logic   word_we; // also write one data word
		logic   word_sel;
		word_t  data;
		tag_t   tag;
		logic   valid;
		logic   dirty;
	} frame_wr_t;

	typedef struct packed {
		logic         ren;
		logic         wen;
		dcache_addr_t addr;
		word_t        store;
	} dp_req_t;

	typedef struct packed {
		logic  hit;
		word_t load;
	} dp_rsp_t;

	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	typedef struct packed {
		logic  dwait;
		word_t load;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		idle,
		wback1,
		wback2,
		alloc1,
		alloc2,
		flush1,
		flush2,
		flushed
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: dcache_frames.sv
// **********************************************************************
// frame storage for both ways of the data cache
// looks up the request address, serves the victim and flush frames,
// and applies one update from the controller per clock
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module dcache_frames (
	input  logic                     CLK,
	input  logic                     nRST,
	input  dcache_pkg::dcache_addr_t lookup_addr,
	output dcache_pkg::set_status_t  status,
	output dcache_pkg::word_t        hit_word,
	input  logic                     victim_way,
	output dcache_pkg::frame_t       victim_frame,
	input  logic [3:0]               flush_frame_num,
	output dcache_pkg::frame_t       flush_frame,
	input  dcache_pkg::frame_wr_t    frame_wr
);

	logic [dcache_pkg::num_ways-1:0][dcache_pkg::num_sets-1:0] valid_q;
	logic [dcache_pkg::num_ways-1:0][dcache_pkg::num_sets-1:0] dirty_q;
	dcache_pkg::tag_t  tag_q [dcache_pkg::num_ways][dcache_pkg::num_sets];
	dcache_pkg::word_t data_q [dcache_pkg::num_ways][dcache_pkg::num_sets]
		[dcache_pkg::words_per_block];

	dcache_pkg::index_t                idx;
	logic [dcache_pkg::num_ways-1:0]   match;

	// gather one stored frame into the packed view
	function automatic dcache_pkg::frame_t read_frame(input logic way,
			input dcache_pkg::index_t set);
		dcache_pkg::frame_t f;
		f.valid = valid_q[way][set];
		f.dirty = dirty_q[way][set];
		f.tag   = tag_q[way][set];
		for (int w = 0; w < dcache_pkg::words_per_block; w++) begin
			f.data[w] = data_q[way][set][w];
		end
		return f;
	endfunction

	assign idx = lookup_addr.fields.index;

	always_comb begin
		for (int w = 0; w < dcache_pkg::num_ways; w++) begin
			match[w]        = valid_q[w][idx] && (tag_q[w][idx] == lookup_addr.fields.tag);
			status.valid[w] = valid_q[w][idx];
			status.dirty[w] = dirty_q[w][idx];
		end
		status.hit     = |match;
		status.hit_way = match[1]; // way 0 unless way 1 matched
		hit_word       = data_q[status.hit_way][idx][lookup_addr.fields.word_sel];

		victim_frame = read_frame(victim_way, idx);
		// low bit is the way, upper bits the set
		flush_frame  = read_frame(flush_frame_num[0], flush_frame_num[3:1]);
	end

	// state bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (frame_wr.en) begin
			valid_q[frame_wr.way][frame_wr.index] <= frame_wr.valid;
			dirty_q[frame_wr.way][frame_wr.index] <= frame_wr.dirty;
		end
	end

	// tags and block data
	always_ff @(posedge CLK) begin
		if (frame_wr.en) begin
			tag_q[frame_wr.way][frame_wr.index] <= frame_wr.tag;
			if (frame_wr.word_we) begin
				data_q[frame_wr.way][frame_wr.index][frame_wr.word_sel] <= frame_wr.data;
			end
		end
	end

endmodule

`default_nettype wire

// File: dcache_lru.sv
// **********************************************************************
// replacement state for the data cache, one bit per set
// picks the victim way for the request set and records each hit
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module dcache_lru (
	input  logic                    CLK,
	input  logic                    nRST,
	input  dcache_pkg::index_t      index,
	input  dcache_pkg::set_status_t status,
	input  logic                    touch,
	input  logic                    touch_way,
	output logic                    victim_way
);

	// names the least recently used way of each set
	logic [dcache_pkg::num_sets-1:0] lru_q;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru_q <= '0;
		end else if (touch) begin
			lru_q[index] <= ~touch_way; // other way is now the older one
		end
	end

	// empty ways fill before anything gets evicted
	always_comb begin
		if (!status.valid[0]) begin
			victim_way = 1'b0;
		end else if (!status.valid[1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[index];
		end
	end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
// **********************************************************************
// data cache controller FSM
// serves hits from idle, writes back dirty victims, fills missed blocks
// one word at a time and walks all frames on halt to flush dirty data
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
	input  logic                    CLK,
	input  logic                    nRST,
	input  dcache_pkg::dp_req_t     dp_req,
	input  logic                    halt,
	input  dcache_pkg::set_status_t status,
	input  dcache_pkg::word_t       hit_word,
	input  logic                    victim_way,
	input  dcache_pkg::frame_t      victim_frame,
	input  dcache_pkg::frame_t      flush_frame,
	output logic [3:0]              flush_frame_num,
	output dcache_pkg::frame_wr_t   frame_wr,
	output logic                    touch,
	output logic                    touch_way,
	output dcache_pkg::dp_rsp_t     dp_rsp,
	output logic                    flushed,
	output dcache_pkg::mem_req_t    mem_req,
	input  dcache_pkg::mem_rsp_t    mem_rsp
);

	dcache_pkg::ctrl_state_t state;
	dcache_pkg::ctrl_state_t next_state;
	logic [4:0]              flush_cnt;
	logic [4:0]              next_flush_cnt;
	logic                    victim_q;
	logic                    next_victim;
	logic                    req;

	// word address of one half of a block
	function automatic dcache_pkg::word_t word_addr(input dcache_pkg::tag_t tag,
			input dcache_pkg::index_t set, input logic word_sel);
		dcache_pkg::dcache_addr_t a;
		a.fields.tag      = tag;
		a.fields.index    = set;
		a.fields.word_sel = word_sel;
		a.fields.byte_off = 2'b00;
		return a.word;
	endfunction

	assign req             = dp_req.ren | dp_req.wen;
	assign flush_frame_num = flush_cnt[3:0];
	assign flushed         = (state == dcache_pkg::flushed);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= dcache_pkg::idle;
			flush_cnt <= '0;
			victim_q  <= 1'b0;
		end else begin
			state     <= next_state;
			flush_cnt <= next_flush_cnt;
			victim_q  <= next_victim;
		end
	end

	always_comb begin
		next_state     = state;
		next_flush_cnt = flush_cnt;
		next_victim    = victim_q;
		dp_rsp.hit     = 1'b0;
		dp_rsp.load    = hit_word;
		touch          = 1'b0;
		touch_way      = status.hit_way;

		frame_wr       = '0;
		frame_wr.way   = victim_q; // fills and write-backs go to the latched way
		frame_wr.index = dp_req.addr.fields.index;
		frame_wr.tag   = dp_req.addr.fields.tag;
		frame_wr.data  = mem_rsp.load;

		mem_req        = '0;
		mem_req.addr   = dp_req.addr.word;

		case (state)
			dcache_pkg::idle: begin
				if (req && status.hit) begin
					dp_rsp.hit = 1'b1;
					touch      = 1'b1;
					if (dp_req.wen) begin
						frame_wr.en       = 1'b1;
						frame_wr.way      = status.hit_way;
						frame_wr.word_we  = 1'b1;
						frame_wr.word_sel = dp_req.addr.fields.word_sel;
						frame_wr.data     = dp_req.store;
						frame_wr.valid    = 1'b1;
						frame_wr.dirty    = 1'b1;
					end
				end else if (req) begin
					next_victim = victim_way;
					if (status.dirty[victim_way]) begin
						next_state = dcache_pkg::wback1;
					end else begin
						next_state = dcache_pkg::alloc1;
					end
				end else if (halt) begin
					next_flush_cnt = '0;
					next_state     = dcache_pkg::flush1;
				end
			end

			dcache_pkg::wback1: begin
				mem_req.wen   = 1'b1;
				mem_req.addr  = word_addr(victim_frame.tag, dp_req.addr.fields.index, 1'b0);
				mem_req.store = victim_frame.data[0];
				if (!mem_rsp.dwait) begin
					next_state = dcache_pkg::wback2;
				end
			end

			dcache_pkg::wback2: begin
				mem_req.wen   = 1'b1;
				mem_req.addr  = word_addr(victim_frame.tag, dp_req.addr.fields.index, 1'b1);
				mem_req.store = victim_frame.data[1];
				if (!mem_rsp.dwait) begin
					frame_wr.en    = 1'b1; // block now clean in memory
					frame_wr.tag   = victim_frame.tag;
					frame_wr.valid = 1'b1;
					next_state     = dcache_pkg::alloc1;
				end
			end

			dcache_pkg::alloc1: begin
				mem_req.ren  = 1'b1;
				mem_req.addr = word_addr(dp_req.addr.fields.tag, dp_req.addr.fields.index, 1'b0);
				if (!mem_rsp.dwait) begin
					frame_wr.en      = 1'b1;
					frame_wr.word_we = 1'b1; // new tag, still invalid
					next_state       = dcache_pkg::alloc2;
				end
			end

			dcache_pkg::alloc2: begin
				mem_req.ren  = 1'b1;
				mem_req.addr = word_addr(dp_req.addr.fields.tag, dp_req.addr.fields.index, 1'b1);
				if (!mem_rsp.dwait) begin
					frame_wr.en       = 1'b1;
					frame_wr.word_we  = 1'b1;
					frame_wr.word_sel = 1'b1;
					frame_wr.valid    = 1'b1;
					next_state        = dcache_pkg::idle; // request hits next cycle
				end
			end

			dcache_pkg::flush1: begin
				if (flush_cnt == 5'(dcache_pkg::num_frames)) begin
					next_state = dcache_pkg::flushed;
				end else if (flush_frame.dirty) begin
					mem_req.wen   = 1'b1;
					mem_req.addr  = word_addr(flush_frame.tag, flush_cnt[3:1], 1'b1);
					mem_req.store = flush_frame.data[1];
					if (!mem_rsp.dwait) begin
						next_state = dcache_pkg::flush2;
					end
				end else begin
					next_flush_cnt = flush_cnt + 5'd1; // clean frame, skip
				end
			end

			dcache_pkg::flush2: begin
				mem_req.wen   = 1'b1;
				mem_req.addr  = word_addr(flush_frame.tag, flush_cnt[3:1], 1'b0);
				mem_req.store = flush_frame.data[0];
				if (!mem_rsp.dwait) begin
					frame_wr.en    = 1'b1;
					frame_wr.way   = flush_cnt[0];
					frame_wr.index = flush_cnt[3:1];
					frame_wr.tag   = flush_frame.tag;
					next_flush_cnt = flush_cnt + 5'd1;
					next_state     = dcache_pkg::flush1;
				end
			end

			dcache_pkg::flushed: begin
				next_state = dcache_pkg::flushed; // held until reset
			end

			default: begin
				next_state = dcache_pkg::idle;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: dcache.sv
// **********************************************************************
// two-way write-back data cache, 8 sets of two-word blocks
// sits between the datapath request port and a single memory port
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module dcache (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::dp_req_t  dp_req,
	input  logic                 halt,
	output dcache_pkg::dp_rsp_t  dp_rsp,
	output logic                 flushed,
	output dcache_pkg::mem_req_t mem_req,
	input  dcache_pkg::mem_rsp_t mem_rsp
);

	dcache_pkg::set_status_t status;
	dcache_pkg::word_t       hit_word;
	logic                    victim_way;
	dcache_pkg::frame_t      victim_frame;
	logic [3:0]              flush_frame_num;
	dcache_pkg::frame_t      flush_frame;
	dcache_pkg::frame_wr_t   frame_wr;
	logic                    touch;
	logic                    touch_way;

	dcache_frames i_frames (
		.CLK             (CLK),
		.nRST            (nRST),
		.lookup_addr     (dp_req.addr),
		.status          (status),
		.hit_word        (hit_word),
		.victim_way      (victim_way),
		.victim_frame    (victim_frame),
		.flush_frame_num (flush_frame_num),
		.flush_frame     (flush_frame),
		.frame_wr        (frame_wr)
	);

	dcache_lru i_lru (
		.CLK        (CLK),
		.nRST       (nRST),
		.index      (dp_req.addr.fields.index),
		.status     (status),
		.touch      (touch),
		.touch_way  (touch_way),
		.victim_way (victim_way)
	);

	dcache_ctrl i_ctrl (
		.CLK             (CLK),
		.nRST            (nRST),
		.dp_req          (dp_req),
		.halt            (halt),
		.status          (status),
		.hit_word        (hit_word),
		.victim_way      (victim_way),
		.victim_frame    (victim_frame),
		.flush_frame     (flush_frame),
		.flush_frame_num (flush_frame_num),
		.frame_wr        (frame_wr),
		.touch           (touch),
		.touch_way       (touch_way),
		.dp_rsp          (dp_rsp),
		.flushed         (flushed),
		.mem_req         (mem_req),
		.mem_rsp         (mem_rsp)
	);

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// **********************************************************************
// testbench memory for the data cache memory port
// words start as address xor a fixed key, each transfer waits 0 to 3
// cycles, and every completed write is kept in a log for the checks
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::mem_req_t mem_req,
	output dcache_pkg::mem_rsp_t mem_rsp
);

	localparam int                mem_words   = 1024; // covers byte addresses below 4 KB
	localparam int                log_depth   = 512;
	localparam dcache_pkg::word_t pattern_key = 32'hA5A50000;

	dcache_pkg::word_t mem [mem_words];
	dcache_pkg::word_t log_addr [log_depth];
	dcache_pkg::word_t log_data [log_depth];
	int                log_count = 0;
	int                rd_count  = 0; // completed word reads
	int                seed      = 86;
	logic [1:0]        wait_cnt;
	logic              active;

	initial begin
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = dcache_pkg::word_t'(i * 4) ^ pattern_key;
		end
	end

	assign active        = mem_req.ren | mem_req.wen;
	assign mem_rsp.dwait = active && (wait_cnt != 2'd0);
	assign mem_rsp.load  = mem[mem_req.addr[11:2]];

	// count down the wait, then finish the word and draw the next wait
	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			wait_cnt <= 2'($random(seed));
		end else if (active) begin
			if (wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end else begin
				if (mem_req.wen) begin
					mem[mem_req.addr[11:2]] <= mem_req.store;
					if (log_count < log_depth) begin
						log_addr[log_count] <= mem_req.addr;
						log_data[log_count] <= mem_req.store;
					end
					log_count <= log_count + 1;
				end else begin
					rd_count <= rd_count + 1;
				end
				wait_cnt <= 2'($random(seed));
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_dcache.sv
// **********************************************************************
// testbench top for the data cache
// runs directed tests against the DUT with a waiting memory model,
// prints one line per test and a closing summary
// **********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

	localparam int                timeout_cycles = 200;
	localparam int                sample_delay   = 2; // middle of the low phase
	localparam dcache_pkg::word_t pattern_key    = 32'hA5A50000;

	logic                 CLK;
	logic                 nRST;
	logic                 halt;
	logic                 flushed;
	dcache_pkg::dp_req_t  dp_req;
	dcache_pkg::dp_rsp_t  dp_rsp;
	dcache_pkg::mem_req_t mem_req;
	dcache_pkg::mem_rsp_t mem_rsp;

	string test_name;
	int    test_errors = 0;
	int    errors      = 0;
	int    checks      = 0;
	int    tests       = 0;
	logic  stuck       = 1'b0; // set once the DUT stops answering
	int    seed        = 86;

	dcache i_dut (
		.CLK     (CLK),
		.nRST    (nRST),
		.dp_req  (dp_req),
		.halt    (halt),
		.dp_rsp  (dp_rsp),
		.flushed (flushed),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	tb_mem_model i_mem (
		.CLK     (CLK),
		.nRST    (nRST),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// initial memory contents
	function automatic dcache_pkg::word_t pattern(input dcache_pkg::word_t addr);
		return addr ^ pattern_key;
	endfunction

	// blocks of tags 16 to 18 in sets 0 to 3
	function automatic dcache_pkg::word_t bp_addr(input int k);
		return 32'h400 + 32'(k / 8) * 32'd64 + 32'((k / 2) % 4) * 32'd8 + 32'(k % 2) * 32'd4;
	endfunction

	task automatic check_word(input dcache_pkg::word_t exp, input dcache_pkg::word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			test_errors++;
			$display("Fail %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	task automatic check_flag(input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			test_errors++;
			$display("Fail %s: expected %b, actual %b", test_name, exp, act);
		end
	endtask

	task automatic report_stall(input string what);
		errors++;
		test_errors++;
		stuck = 1'b1;
		$display("%s: %s within %0d cycles", test_name, what, timeout_cycles);
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests++;
		if (test_errors == 0) begin
			$display("%s: ok", test_name);
		end else begin
			$display("%s: %0d errors", test_name, test_errors);
		end
	endtask

	task automatic apply_reset();
		@(negedge CLK);
		nRST   = 1'b0;
		halt   = 1'b0;
		dp_req = '0;
		repeat (4) @(negedge CLK);
		nRST = 1'b1;
	endtask

	// one request held until hit, dropped on the next falling edge
	task automatic access(input logic wen, input dcache_pkg::word_t addr,
			input dcache_pkg::word_t store, output dcache_pkg::word_t load);
		int cycles;
		load = '0;
		if (stuck) begin
			return;
		end
		@(negedge CLK);
		dp_req.ren       = !wen;
		dp_req.wen       = wen;
		dp_req.addr.word = addr;
		dp_req.store     = store;
		cycles           = 0;
		#sample_delay;
		while (!dp_rsp.hit && cycles < timeout_cycles) begin
			@(negedge CLK);
			#sample_delay;
			cycles++;
		end
		if (dp_rsp.hit) begin
			load = dp_rsp.load;
		end else begin
			report_stall($sformatf("no hit for address %h", addr));
		end
		@(negedge CLK);
		dp_req.ren = 1'b0;
		dp_req.wen = 1'b0;
	endtask

	task automatic read_expect(input dcache_pkg::word_t addr, input dcache_pkg::word_t exp);
		dcache_pkg::word_t load;
		access(1'b0, addr, '0, load);
		check_word(exp, load);
	endtask

	task automatic write_word(input dcache_pkg::word_t addr, input dcache_pkg::word_t data);
		dcache_pkg::word_t load;
		access(1'b1, addr, data, load);
	endtask

	task automatic read_miss_then_hit();
		int rd_before;
		start_test("read_miss_then_hit");
		read_expect(32'h008, pattern(32'h008));
		rd_before = i_mem.rd_count;
		read_expect(32'h008, pattern(32'h008));
		read_expect(32'h00C, pattern(32'h00C)); // other word of the block
		check_word(32'(rd_before), 32'(i_mem.rd_count));
		finish_test();
	endtask

	task automatic write_then_read();
		start_test("write_then_read");
		write_word(32'h010, 32'h1234_5678);
		read_expect(32'h010, 32'h1234_5678);
		read_expect(32'h014, pattern(32'h014));
		finish_test();
	endtask

	// A, B and C all land in set 0
	task automatic replace_and_write_back();
		dcache_pkg::word_t a;
		dcache_pkg::word_t b;
		dcache_pkg::word_t c;
		dcache_pkg::word_t b_val;
		int                log_start;
		int                rd_before;
		a     = 32'h040;
		b     = 32'h080;
		c     = 32'h0C0;
		b_val = 32'hBEEF_0080;
		start_test("replace_and_write_back");
		read_expect(a, pattern(a));
		write_word(b, b_val);
		read_expect(a, pattern(a)); // B is now the older way
		log_start = i_mem.log_count;
		read_expect(c, pattern(c));
		check_word(32'(log_start + 2), 32'(i_mem.log_count));
		check_word(b, i_mem.log_addr[log_start]);
		check_word(b_val, i_mem.log_data[log_start]);
		check_word(b + 32'h4, i_mem.log_addr[log_start + 1]);
		check_word(pattern(b + 32'h4), i_mem.log_data[log_start + 1]);
		rd_before = i_mem.rd_count;
		read_expect(a, pattern(a));
		check_word(32'(rd_before), 32'(i_mem.rd_count));
		read_expect(b, b_val);
		finish_test();
	endtask

	task automatic flush_on_halt();
		dcache_pkg::word_t addrs [4];
		dcache_pkg::word_t vals [4];
		dcache_pkg::word_t base;
		dcache_pkg::word_t other;
		int                log_start;
		int                n0;
		int                n1;
		int                cycles;
		addrs = '{32'h300, 32'h31C, 32'h328, 32'h338}; // sets 0, 3, 5, 7
		vals  = '{32'h0DE0_0300, 32'h0DE0_031C, 32'h0DE0_0328, 32'h0DE0_0338};
		start_test("flush_on_halt");
		apply_reset();
		for (int i = 0; i < 4; i++) begin
			write_word(addrs[i], vals[i]);
		end
		read_expect(32'h348, pattern(32'h348)); // clean frame in set 1
		log_start = i_mem.log_count;
		@(negedge CLK);
		halt   = 1'b1;
		cycles = 0;
		while (!flushed && cycles < timeout_cycles) begin
			@(negedge CLK);
			cycles++;
		end
		if (!flushed) begin
			report_stall("flushed did not rise after halt");
		end
		check_flag(1'b1, flushed);
		for (int i = 0; i < 4; i++) begin
			base  = addrs[i] & ~32'h7;
			other = addrs[i] ^ 32'h4;
			check_word(vals[i], i_mem.mem[addrs[i][11:2]]);
			check_word(pattern(other), i_mem.mem[other[11:2]]);
			n0 = 0;
			n1 = 0;
			for (int j = log_start; j < i_mem.log_count; j++) begin
				if (i_mem.log_addr[j] == base) begin
					n0++;
				end
				if (i_mem.log_addr[j] == base + 32'h4) begin
					n1++;
				end
			end
			check_word(32'd1, 32'(n0));
			check_word(32'd1, 32'(n1));
		end
		check_word(32'd8, 32'(i_mem.log_count - log_start)); // nothing from clean frames
		finish_test();
	endtask

	task automatic random_back_pressure();
		dcache_pkg::word_t ref_mem [24];
		dcache_pkg::word_t data;
		int                k;
		start_test("random_back_pressure");
		apply_reset();
		check_flag(1'b0, flushed); // reset leaves the flushed state
		for (int i = 0; i < 24; i++) begin
			ref_mem[i] = pattern(bp_addr(i));
		end
		repeat (80) begin
			k = {$random(seed)} % 24;
			if ($random(seed) & 1) begin
				data = $random(seed);
				write_word(bp_addr(k), data);
				ref_mem[k] = data;
			end else begin
				read_expect(bp_addr(k), ref_mem[k]);
			end
		end
		finish_test();
	endtask

	initial begin
		nRST   = 1'b0;
		halt   = 1'b0;
		dp_req = '0;
		apply_reset();
		read_miss_then_hit();
		write_then_read();
		replace_and_write_back();
		flush_on_halt();
		random_back_pressure();
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dcache.f
dcache_pkg.sv
dcache_frames.sv
dcache_lru.sv
dcache_ctrl.sv
dcache.sv
tb_mem_model.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_frames.sv
  - dcache_lru.sv
  - dcache_ctrl.sv
  - dcache.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_dcache.sv
